// File: mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define XLEN        32
`define REG_AW      5
`define NUM_REGS    32
`define LINK_REG    5'd31       // jal and the linking branches write here

// primary opcodes, inst[31:26]
`define OP_SPECIAL  6'h00
`define OP_REGIMM   6'h01
`define OP_J        6'h02
`define OP_JAL      6'h03
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_BLEZ     6'h06
`define OP_BGTZ     6'h07
`define OP_ADDI     6'h08
`define OP_ADDIU    6'h09
`define OP_SLTI     6'h0a
`define OP_SLTIU    6'h0b
`define OP_ANDI     6'h0c
`define OP_ORI      6'h0d
`define OP_XORI     6'h0e
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// function codes of the SPECIAL class
`define FN_SLL      6'h00
`define FN_SRL      6'h02
`define FN_SRA      6'h03
`define FN_SLLV     6'h04
`define FN_SRLV     6'h06
`define FN_SRAV     6'h07
`define FN_JR       6'h08
`define FN_JALR     6'h09
`define FN_ADD      6'h20
`define FN_ADDU     6'h21
`define FN_SUB      6'h22
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_XOR      6'h26
`define FN_NOR      6'h27
`define FN_SLT      6'h2a
`define FN_SLTU     6'h2b

// REGIMM codes, carried in the rt field
`define RT_BLTZ     5'h00
`define RT_BGEZ     5'h01
`define RT_BLTZAL   5'h10
`define RT_BGEZAL   5'h11

`endif

// File: mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

    typedef logic [`XLEN-1:0]   word_t;     // data word or pc
    typedef logic [`REG_AW-1:0] reg_idx_t;  // gpr index
    typedef logic [15:0]        imm_t;      // raw immediate field

    // encoded ALU operation handed to execute
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

endpackage

// File: reg_file.sv
`include "mips_defines.svh"

module reg_file (
    input  logic               clk,
    input  mips_pkg::reg_idx_t raddr1,
    input  mips_pkg::reg_idx_t raddr2,
    output mips_pkg::word_t    rdata1,
    output mips_pkg::word_t    rdata2,
    input  logic               we,
    input  mips_pkg::reg_idx_t waddr,
    input  mips_pkg::word_t    wdata
);

    mips_pkg::word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, $zero is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: inst_decoder.sv
`include "mips_defines.svh"

module inst_decoder (
    input  mips_pkg::word_t    inst,
    output mips_pkg::reg_idx_t rs,
    output mips_pkg::reg_idx_t rt,
    output mips_pkg::alu_op_t  alu_op,
    output logic               src1_is_sa,
    output logic               src1_is_pc,
    output logic               src2_is_imm,
    output logic               src2_is_8,
    output logic               mem_re,
    output logic               mem_we,
    output logic               gpr_we,
    output logic               ovf_check,
    output logic               reserved_inst,
    output mips_pkg::reg_idx_t dest,
    output mips_pkg::imm_t     imm,
    output logic [25:0]        jidx,
    output logic               src_uses_rs,
    output logic               src_uses_rt,
    output logic               is_load,
    output logic               is_branch,
    output logic               is_jump_reg,
    output logic               is_jump_imm,
    output logic               is_beq,
    output logic               is_bne,
    output logic               is_bgez,
    output logic               is_bgtz,
    output logic               is_blez,
    output logic               is_bltz
);

    logic [5:0] op;
    logic [5:0] func;
    logic [4:0] sa;
    mips_pkg::reg_idx_t rd;
    logic rtype;                // SPECIAL with sa zero
    logic shamt_op;             // SPECIAL with rs zero
    logic inst_add, inst_addu, inst_sub, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addi, inst_addiu, inst_slti, inst_sltiu;
    logic inst_andi, inst_ori, inst_xori, inst_lui, inst_lw, inst_sw;
    logic inst_bltzal, inst_bgezal, inst_j, inst_jal, inst_jr, inst_jalr;
    logic r_alu, imm_form, link, kept;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];
    assign imm  = inst[15:0];
    assign jidx = inst[25:0];

    assign rtype    = (op == `OP_SPECIAL) && (sa == 5'd0);
    assign shamt_op = (op == `OP_SPECIAL) && (rs == 5'd0);

    assign inst_add    = rtype && (func == `FN_ADD);
    assign inst_addu   = rtype && (func == `FN_ADDU);
    assign inst_sub    = rtype && (func == `FN_SUB);
    assign inst_subu   = rtype && (func == `FN_SUBU);
    assign inst_slt    = rtype && (func == `FN_SLT);
    assign inst_sltu   = rtype && (func == `FN_SLTU);
    assign inst_and    = rtype && (func == `FN_AND);
    assign inst_or     = rtype && (func == `FN_OR);
    assign inst_xor    = rtype && (func == `FN_XOR);
    assign inst_nor    = rtype && (func == `FN_NOR);
    assign inst_sllv   = rtype && (func == `FN_SLLV);
    assign inst_srlv   = rtype && (func == `FN_SRLV);
    assign inst_srav   = rtype && (func == `FN_SRAV);
    assign inst_sll    = shamt_op && (func == `FN_SLL);
    assign inst_srl    = shamt_op && (func == `FN_SRL);
    assign inst_sra    = shamt_op && (func == `FN_SRA);
    assign inst_jr     = rtype && (func == `FN_JR) && (rt == 5'd0) && (rd == 5'd0);
    assign inst_jalr   = rtype && (func == `FN_JALR) && (rt == 5'd0);
    assign inst_addi   = (op == `OP_ADDI);
    assign inst_addiu  = (op == `OP_ADDIU);
    assign inst_slti   = (op == `OP_SLTI);
    assign inst_sltiu  = (op == `OP_SLTIU);
    assign inst_andi   = (op == `OP_ANDI);
    assign inst_ori    = (op == `OP_ORI);
    assign inst_xori   = (op == `OP_XORI);
    assign inst_lui    = (op == `OP_LUI) && (rs == 5'd0);
    assign inst_lw     = (op == `OP_LW);
    assign inst_sw     = (op == `OP_SW);
    assign inst_j      = (op == `OP_J);
    assign inst_jal    = (op == `OP_JAL);
    assign inst_bltzal = (op == `OP_REGIMM) && (rt == `RT_BLTZAL);
    assign inst_bgezal = (op == `OP_REGIMM) && (rt == `RT_BGEZAL);

    // linking forms share the plain condition flags
    assign is_beq  = (op == `OP_BEQ);
    assign is_bne  = (op == `OP_BNE);
    assign is_blez = (op == `OP_BLEZ) && (rt == 5'd0);
    assign is_bgtz = (op == `OP_BGTZ) && (rt == 5'd0);
    assign is_bgez = ((op == `OP_REGIMM) && (rt == `RT_BGEZ)) || inst_bgezal;
    assign is_bltz = ((op == `OP_REGIMM) && (rt == `RT_BLTZ)) || inst_bltzal;

    assign is_branch   = is_beq | is_bne | is_blez | is_bgtz | is_bgez | is_bltz;
    assign is_jump_reg = inst_jr | inst_jalr;
    assign is_jump_imm = inst_j | inst_jal;
    assign is_load     = inst_lw;

    assign r_alu    = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu
                    | inst_and | inst_or | inst_xor | inst_nor
                    | inst_sllv | inst_srlv | inst_srav;
    assign imm_form = inst_addi | inst_addiu | inst_slti | inst_sltiu
                    | inst_andi | inst_ori | inst_xori | inst_lui;
    assign link     = inst_jal | inst_jalr | inst_bltzal | inst_bgezal;
    assign kept     = r_alu | src1_is_sa | imm_form | inst_lw | inst_sw
                    | is_branch | is_jump_reg | is_jump_imm;

    always_comb begin
        alu_op = mips_pkg::ALU_ADD;             // also address calc and link pc+8
        if (inst_sub || inst_subu)
            alu_op = mips_pkg::ALU_SUB;
        else if (inst_slt || inst_slti)
            alu_op = mips_pkg::ALU_SLT;
        else if (inst_sltu || inst_sltiu)
            alu_op = mips_pkg::ALU_SLTU;
        else if (inst_and || inst_andi)
            alu_op = mips_pkg::ALU_AND;
        else if (inst_nor)
            alu_op = mips_pkg::ALU_NOR;
        else if (inst_or || inst_ori)
            alu_op = mips_pkg::ALU_OR;
        else if (inst_xor || inst_xori)
            alu_op = mips_pkg::ALU_XOR;
        else if (inst_sll || inst_sllv)
            alu_op = mips_pkg::ALU_SLL;
        else if (inst_srl || inst_srlv)
            alu_op = mips_pkg::ALU_SRL;
        else if (inst_sra || inst_srav)
            alu_op = mips_pkg::ALU_SRA;
        else if (inst_lui)
            alu_op = mips_pkg::ALU_LUI;
    end

    assign src1_is_sa  = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc  = link;
    assign src2_is_8   = link;
    assign src2_is_imm = imm_form | inst_lw | inst_sw;   // logical imms zero-extend in execute
    assign mem_re      = inst_lw;
    assign mem_we      = inst_sw;
    assign ovf_check   = inst_add | inst_addi | inst_sub;

    assign reserved_inst = ~kept;
    assign gpr_we = kept & ~(inst_sw | (is_branch & ~link) | inst_j | inst_jr);

    assign dest = (inst_jal | inst_bltzal | inst_bgezal) ? `LINK_REG :
                  (imm_form | inst_lw)                   ? rt        :
                                                           rd;

    // which register fields are actually read
    assign src_uses_rs = r_alu | (imm_form & ~inst_lui) | inst_lw | inst_sw
                       | is_branch | is_jump_reg;
    assign src_uses_rt = r_alu | src1_is_sa | inst_sw | is_beq | is_bne;

endmodule

// File: operand_bypass.sv
module operand_bypass (
    input  mips_pkg::reg_idx_t rs,
    input  mips_pkg::reg_idx_t rt,
    input  mips_pkg::reg_idx_t es_dest,
    input  mips_pkg::reg_idx_t ms_dest,
    input  mips_pkg::reg_idx_t ws_dest,
    input  logic               ws_we,
    input  mips_pkg::word_t    es_res,
    input  mips_pkg::word_t    ms_res,
    input  mips_pkg::word_t    ws_wdata,
    input  mips_pkg::word_t    rf_rdata1,
    input  mips_pkg::word_t    rf_rdata2,
    input  logic               es_res_valid,
    input  logic               ms_res_valid,
    input  logic               src_uses_rs,
    input  logic               src_uses_rt,
    output mips_pkg::word_t    rs_value,
    output mips_pkg::word_t    rt_value,
    output logic               rs_hit_es,
    output logic               rt_hit_es,
    output logic               load_use_stall
);

    logic rs_hit_ms, rt_hit_ms;
    logic rs_hit_ws, rt_hit_ws;

    // $zero never matches, so it is never forwarded
    function automatic logic hit(input mips_pkg::reg_idx_t src,
                                 input mips_pkg::reg_idx_t dst);
        hit = (src != '0) && (src == dst);
    endfunction

    assign rs_hit_es = hit(rs, es_dest);
    assign rt_hit_es = hit(rt, es_dest);
    assign rs_hit_ms = hit(rs, ms_dest);
    assign rt_hit_ms = hit(rt, ms_dest);
    assign rs_hit_ws = hit(rs, ws_dest) & ws_we;
    assign rt_hit_ws = hit(rt, ws_dest) & ws_we;

    // youngest producer wins
    assign rs_value = rs_hit_es ? es_res   :
                      rs_hit_ms ? ms_res   :
                      rs_hit_ws ? ws_wdata :
                                  rf_rdata1;
    assign rt_value = rt_hit_es ? es_res   :
                      rt_hit_ms ? ms_res   :
                      rt_hit_ws ? ws_wdata :
                                  rf_rdata2;

    // result still on its way from memory
    assign load_use_stall = ~es_res_valid & (rs_hit_es & src_uses_rs | rt_hit_es & src_uses_rt)
                          | ~ms_res_valid & (rs_hit_ms & src_uses_rs | rt_hit_ms & src_uses_rt);

endmodule

// File: branch_unit.sv
module branch_unit (
    input  logic            ds_valid,
    input  mips_pkg::word_t ds_pc,
    input  mips_pkg::word_t rs_value,
    input  mips_pkg::word_t rt_value,
    input  mips_pkg::imm_t  imm,
    input  logic [25:0]     jidx,
    input  logic            is_branch,
    input  logic            is_beq,
    input  logic            is_bne,
    input  logic            is_bgez,
    input  logic            is_bgtz,
    input  logic            is_blez,
    input  logic            is_bltz,
    input  logic            is_jump_reg,
    input  logic            is_jump_imm,
    input  logic            rs_hit_es,
    input  logic            rt_hit_es,
    input  logic            es_res_valid,
    output logic            br_taken,
    output logic            br_stall,
    output mips_pkg::word_t br_target
);

    mips_pkg::word_t pc_plus4;  // equals the fetch pc
    logic rs_eq_rt;
    logic rs_neg;
    logic rs_zero;
    logic cond;

    assign pc_plus4 = ds_pc + 32'd4;
    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_neg   = rs_value[31];
    assign rs_zero  = (rs_value == '0);

    assign cond = is_beq  &  rs_eq_rt
                | is_bne  & ~rs_eq_rt
                | is_bgez & ~rs_neg
                | is_bgtz & ~rs_neg & ~rs_zero
                | is_blez & (rs_neg | rs_zero)
                | is_bltz &  rs_neg;

    assign br_taken = ds_valid & (cond | is_jump_reg | is_jump_imm);

    always_comb begin
        if (is_jump_reg)
            br_target = rs_value;
        else if (is_jump_imm)
            br_target = {pc_plus4[31:28], jidx, 2'b00};
        else
            br_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
    end

    // compare operands not ready while execute holds a load
    assign br_stall = ds_valid & ~es_res_valid
                    & (rs_hit_es & (is_branch | is_jump_reg) | rt_hit_es & (is_beq | is_bne));

endmodule

// File: id_stage.sv
module id_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               fs_valid,
    input  mips_pkg::word_t    fs_inst,
    input  mips_pkg::word_t    fs_pc,
    input  logic               es_allowin,
    input  mips_pkg::reg_idx_t es_dest,
    input  logic               es_res_valid,
    input  mips_pkg::word_t    es_res,
    input  mips_pkg::reg_idx_t ms_dest,
    input  logic               ms_res_valid,
    input  mips_pkg::word_t    ms_res,
    input  logic               ws_we,
    input  mips_pkg::reg_idx_t ws_dest,
    input  mips_pkg::word_t    ws_wdata,
    output logic               ds_allowin,
    output logic               ds_valid_out,
    output mips_pkg::alu_op_t  alu_op,
    output logic               src1_is_sa,
    output logic               src1_is_pc,
    output logic               src2_is_imm,
    output logic               src2_is_8,
    output logic               mem_re,
    output logic               mem_we,
    output logic               gpr_we,
    output mips_pkg::reg_idx_t dest,
    output mips_pkg::imm_t     imm,
    output logic               ovf_check,
    output logic               reserved_inst,
    output mips_pkg::word_t    rs_value,
    output mips_pkg::word_t    rt_value,
    output mips_pkg::word_t    ds_pc,
    output logic               br_taken,
    output logic               br_stall,
    output mips_pkg::word_t    br_target
);

    logic               ds_valid;
    logic               ready_go;
    mips_pkg::word_t    ds_inst;
    mips_pkg::reg_idx_t rs, rt;
    mips_pkg::word_t    rf_rdata1, rf_rdata2;
    logic [25:0]        jidx;
    logic src_uses_rs, src_uses_rt;
    logic is_branch, is_jump_reg, is_jump_imm;
    logic is_beq, is_bne, is_bgez, is_bgtz, is_blez, is_bltz;
    logic rs_hit_es, rt_hit_es, load_use_stall;

    assign ready_go     = ~load_use_stall;
    assign ds_allowin   = ~ds_valid | (ready_go & es_allowin);
    assign ds_valid_out = ds_valid & ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (ws_we),
        .waddr  (ws_dest),
        .wdata  (ws_wdata)
    );

    inst_decoder u_inst_decoder (
        .inst          (ds_inst),
        .rs            (rs),
        .rt            (rt),
        .alu_op        (alu_op),
        .src1_is_sa    (src1_is_sa),
        .src1_is_pc    (src1_is_pc),
        .src2_is_imm   (src2_is_imm),
        .src2_is_8     (src2_is_8),
        .mem_re        (mem_re),
        .mem_we        (mem_we),
        .gpr_we        (gpr_we),
        .ovf_check     (ovf_check),
        .reserved_inst (reserved_inst),
        .dest          (dest),
        .imm           (imm),
        .jidx          (jidx),
        .src_uses_rs   (src_uses_rs),
        .src_uses_rt   (src_uses_rt),
        .is_load       (),
        .is_branch     (is_branch),
        .is_jump_reg   (is_jump_reg),
        .is_jump_imm   (is_jump_imm),
        .is_beq        (is_beq),
        .is_bne        (is_bne),
        .is_bgez       (is_bgez),
        .is_bgtz       (is_bgtz),
        .is_blez       (is_blez),
        .is_bltz       (is_bltz)
    );

    operand_bypass u_operand_bypass (
        .rs             (rs),
        .rt             (rt),
        .es_dest        (es_dest),
        .ms_dest        (ms_dest),
        .ws_dest        (ws_dest),
        .ws_we          (ws_we),
        .es_res         (es_res),
        .ms_res         (ms_res),
        .ws_wdata       (ws_wdata),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .es_res_valid   (es_res_valid),
        .ms_res_valid   (ms_res_valid),
        .src_uses_rs    (src_uses_rs),
        .src_uses_rt    (src_uses_rt),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .rs_hit_es      (rs_hit_es),
        .rt_hit_es      (rt_hit_es),
        .load_use_stall (load_use_stall)
    );

    branch_unit u_branch_unit (
        .ds_valid     (ds_valid),
        .ds_pc        (ds_pc),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .imm          (imm),
        .jidx         (jidx),
        .is_branch    (is_branch),
        .is_beq       (is_beq),
        .is_bne       (is_bne),
        .is_bgez      (is_bgez),
        .is_bgtz      (is_bgtz),
        .is_blez      (is_blez),
        .is_bltz      (is_bltz),
        .is_jump_reg  (is_jump_reg),
        .is_jump_imm  (is_jump_imm),
        .rs_hit_es    (rs_hit_es),
        .rt_hit_es    (rt_hit_es),
        .es_res_valid (es_res_valid),
        .br_taken     (br_taken),
        .br_stall     (br_stall),
        .br_target    (br_target)
    );

endmodule

// File: tb_id_stage.sv
module tb_id_stage;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 21;
    localparam int TIMEOUT  = 50;
    localparam logic [31:0] PC0     = 32'h0040_0100;
    localparam logic [31:0] ES_VAL  = 32'he5e5_0001;
    localparam logic [31:0] MS_VAL  = 32'h3535_0002;
    localparam logic [31:0] WS_VAL  = 32'h5757_0003;

    typedef struct {
        logic [31:0]       inst;
        logic [31:0]       pc;
        logic [4:0]        es_d;
        logic [4:0]        ms_d;
        logic [4:0]        ws_d;
        logic              stall;
        mips_pkg::alu_op_t alu;
        logic [4:0]        dest;
        logic              gpr_we;
        logic              rsv;
        // src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8, mem_re, mem_we, ovf_check
        logic [6:0]        flags;
        logic              taken;
        int                tgt_sel; // 0 unchecked, 1 table, 2 model rs
        logic [31:0]       tgt;
        int                rs_sel;  // 0 model, 1 es, 2 ms, 3 ws
        int                rt_sel;
    } row_t;

    logic clk = 0;
    logic reset;
    logic fs_valid, es_allowin, es_res_valid, ms_res_valid, ws_we;
    logic [31:0] fs_inst, fs_pc, es_res, ms_res, ws_wdata;
    logic [4:0] es_dest, ms_dest, ws_dest;
    logic ds_allowin, ds_valid_out, src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8;
    logic mem_re, mem_we, gpr_we, ovf_check, reserved_inst, br_taken, br_stall;
    mips_pkg::alu_op_t alu_op;
    logic [4:0] dest;
    logic [15:0] imm;
    logic [31:0] rs_value, rt_value, ds_pc, br_target;

    row_t rows [NUM_ROWS];
    int n_rows = 0;
    logic [31:0] rf_model [32];
    int errors = 0;
    int seed = 32'h1418_a39e;

    always #5 clk = ~clk;

    id_stage u_id_stage (.*);

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input logic [31:0] inst, input logic [31:0] pc, input int es_d,
                           input int ms_d, input int ws_d, input int stall,
                           input mips_pkg::alu_op_t alu, input int dst, input int gwe,
                           input int rsv, input logic [6:0] flags, input int taken,
                           input int tgt_sel, input logic [31:0] tgt,
                           input int rs_sel, input int rt_sel);
        rows[n_rows] = '{inst, pc, 5'(es_d), 5'(ms_d), 5'(ws_d), 1'(stall), alu, 5'(dst),
                         1'(gwe), 1'(rsv), flags, 1'(taken), tgt_sel, tgt, rs_sel, rt_sel};
        n_rows++;
    endtask

    function automatic logic [31:0] operand(input int sel, input logic [4:0] idx);
        case (sel)
            1: operand = ES_VAL;
            2: operand = MS_VAL;
            3: operand = WS_VAL;
            default: operand = rf_model[idx];
        endcase
    endfunction

    task automatic wait_valid();
        int n;
        n = 0;
        #1;     // let the bypass inputs settle
        while (!ds_valid_out && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!ds_valid_out) begin
            $display("timeout: ds_valid_out stayed low for %0d cycles at %0t", TIMEOUT, $time);
            errors++;
        end
    endtask

    task automatic idle_bypass();
        es_dest = '0;
        ms_dest = '0;
        ws_dest = '0;
        ws_we = 1'b0;
        es_res_valid = 1'b1;
        ms_res_valid = 1'b1;
        es_res = ES_VAL;
        ms_res = MS_VAL;
        ws_wdata = WS_VAL;
    endtask

    task automatic fill_table();
        // decode and forwarding
        add_row(32'h00a63821, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 7, 1, 0, 7'b0000000,
                0, 0, 0, 0, 0);
        add_row(32'h24a61234, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 6, 1, 0, 7'b0010000,
                0, 0, 0, 0, 0);
        add_row(32'h00a6382a, PC0, 5, 6, 0, 0, mips_pkg::ALU_SLT, 7, 1, 0, 7'b0000000,
                0, 0, 0, 1, 2);
        add_row(32'h30a600ff, PC0, 0, 5, 5, 0, mips_pkg::ALU_AND, 6, 1, 0, 7'b0010000,
                0, 0, 0, 2, 0);
        add_row(32'h000638c0, PC0, 0, 0, 6, 0, mips_pkg::ALU_SLL, 7, 1, 0, 7'b1000000,
                0, 0, 0, 0, 3);
        add_row(32'h3c06abcd, PC0, 0, 0, 0, 0, mips_pkg::ALU_LUI, 6, 1, 0, 7'b0010000,
                0, 0, 0, 0, 0);
        add_row(32'h8ca60010, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 6, 1, 0, 7'b0010100,
                0, 0, 0, 0, 0);
        add_row(32'haca60008, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 0, 0, 0, 7'b0010010,
                0, 0, 0, 0, 0);
        // branches and jumps, pc+4 = 0x0040_0104
        add_row(32'h10a50004, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 0, 0, 0, 7'b0000000,
                1, 1, 32'h0040_0114, 0, 0);
        add_row(32'h14a5fffe, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 31, 0, 0, 7'b0000000,
                0, 1, 32'h0040_00fc, 0, 0);
        add_row(32'h18000008, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 0, 0, 0, 7'b0000000,
                1, 1, 32'h0040_0124, 0, 0);
        add_row(32'h1c000008, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 0, 0, 0, 7'b0000000,
                0, 1, 32'h0040_0124, 0, 0);
        add_row(32'h04010001, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 0, 0, 0, 7'b0000000,
                1, 1, 32'h0040_0108, 0, 0);
        add_row(32'h04000001, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 0, 0, 0, 7'b0000000,
                0, 1, 32'h0040_0108, 0, 0);
        add_row(32'h04110002, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 31, 1, 0, 7'b0101000,
                1, 1, 32'h0040_010c, 0, 0);
        add_row(32'h08100040, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 0, 0, 0, 7'b0000000,
                1, 1, 32'h0040_0100, 0, 0);
        add_row(32'h0c100050, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 31, 1, 0, 7'b0101000,
                1, 1, 32'h0040_0140, 0, 0);
        add_row(32'h00a00008, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 0, 0, 0, 7'b0000000,
                1, 2, 0, 0, 0);
        // load-use stalls, then a reserved opcode
        add_row(32'h00a63820, PC0, 5, 0, 0, 1, mips_pkg::ALU_ADD, 7, 1, 0, 7'b0000001,
                0, 0, 0, 1, 0);
        add_row(32'h10c60004, PC0, 6, 0, 0, 1, mips_pkg::ALU_ADD, 0, 0, 0, 7'b0000000,
                1, 1, 32'h0040_0114, 1, 1);
        add_row(32'hfc000000, PC0, 0, 0, 0, 0, mips_pkg::ALU_ADD, 0, 0, 1, 7'b0000000,
                0, 0, 0, 0, 0);
    endtask

    task automatic run_row(input row_t r);
        fs_valid = 1'b1;
        fs_inst = r.inst;
        fs_pc = r.pc;
        @(posedge clk);
        #1;
        fs_valid = 1'b0;
        es_dest = r.es_d;
        ms_dest = r.ms_d;
        ws_dest = r.ws_d;
        ws_we = (r.ws_d != 0);
        es_res_valid = !r.stall;
        if (r.stall) begin
            #3;
            check("ds_valid_out", 32'(ds_valid_out), 32'(0));
            check("br_stall", 32'(br_stall), 32'(r.tgt_sel != 0));
            @(posedge clk);
            #1;
            es_res_valid = 1'b1;
        end
        wait_valid();
        #3;
        check("alu_op", 32'(alu_op), 32'(r.alu));
        check("dest", 32'(dest), 32'(r.dest));
        check("gpr_we", 32'(gpr_we), 32'(r.gpr_we));
        check("reserved_inst", 32'(reserved_inst), 32'(r.rsv));
        check("src1_is_sa", 32'(src1_is_sa), 32'(r.flags[6]));
        check("src1_is_pc", 32'(src1_is_pc), 32'(r.flags[5]));
        check("src2_is_imm", 32'(src2_is_imm), 32'(r.flags[4]));
        check("src2_is_8", 32'(src2_is_8), 32'(r.flags[3]));
        check("mem_re", 32'(mem_re), 32'(r.flags[2]));
        check("mem_we", 32'(mem_we), 32'(r.flags[1]));
        check("ovf_check", 32'(ovf_check), 32'(r.flags[0]));
        check("imm", 32'(imm), 32'(r.inst[15:0]));
        check("ds_pc", ds_pc, r.pc);
        check("rs_value", rs_value, operand(r.rs_sel, r.inst[25:21]));
        check("rt_value", rt_value, operand(r.rt_sel, r.inst[20:16]));
        check("br_taken", 32'(br_taken), 32'(r.taken));
        if (r.tgt_sel == 1)
            check("br_target", br_target, r.tgt);
        else if (r.tgt_sel == 2)
            check("br_target", br_target, rf_model[r.inst[25:21]]);
        @(posedge clk);
        if (ws_we)
            rf_model[ws_dest] = ws_wdata;   // that edge wrote the register file
        #1;
        idle_bypass();
    endtask

    initial begin
        reset = 1'b1;
        fs_valid = 1'b0;
        fs_inst = '0;
        fs_pc = '0;
        es_allowin = 1'b1;
        idle_bypass();
        rf_model[0] = '0;
        fill_table();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        check("ds_valid_out", 32'(ds_valid_out), 32'(0));
        check("br_taken", 32'(br_taken), 32'(0));
        check("ds_allowin", 32'(ds_allowin), 32'(1));

        // preload gprs through writeback
        for (int i = 1; i < 32; i++) begin
            ws_we = 1'b1;
            ws_dest = 5'(i);
            ws_wdata = $random(seed);
            rf_model[i] = ws_wdata;
            @(posedge clk);
            #1;
        end
        idle_bypass();

        for (int i = 0; i < n_rows; i++)
            run_row(rows[i]);

        // back-pressure from execute, lui r6,0x1111 must hold
        es_allowin = 1'b0;
        fs_valid = 1'b1;
        fs_inst = 32'h3c06_1111;
        fs_pc = 32'h0000_0500;
        @(posedge clk);
        #1;
        fs_inst = 32'h00a6_3821;
        fs_pc = 32'h0000_0600;
        repeat (3) begin
            @(posedge clk);
            #1;
            check("ds_allowin", 32'(ds_allowin), 32'(0));
            check("ds_pc", ds_pc, 32'h0000_0500);
            check("alu_op", 32'(alu_op), 32'(mips_pkg::ALU_LUI));
            check("imm", 32'(imm), 32'h1111);
        end
        es_allowin = 1'b1;
        fs_valid = 1'b0;
        @(posedge clk);
        #1;
        check("ds_allowin", 32'(ds_allowin), 32'(1));

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: id_stage.f
+incdir+.
mips_pkg.sv
reg_file.sv
inst_decoder.sv
operand_bypass.sv
branch_unit.sv
id_stage.sv
tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_id_stage
FILELIST  ?= id_stage.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
